//--- logic/histoGeomPkg.sv
package histoGeomPkg;

    localparam int TIME_BITS     = 10;
    localparam int BIN_BITS      = 6;   // bin is the top of the time code
    localparam int NUM_BINS      = 64;
    localparam int COUNT_BITS    = 8;
    localparam int REG_DATA_BITS = 16;
    localparam int REG_ADDR_BITS = 2;

    typedef logic [TIME_BITS-1:0]     timeCode_t;
    typedef logic [BIN_BITS-1:0]      binIdx_t;
    typedef logic [COUNT_BITS-1:0]    binCount_t;
    typedef logic [REG_DATA_BITS-1:0] regData_t;
    typedef logic [REG_ADDR_BITS-1:0] regAddr_t;

    localparam binIdx_t   LAST_BIN  = binIdx_t'(NUM_BINS - 1);
    localparam binCount_t COUNT_MAX = '1;   // bins stick at 255
    localparam regData_t  EVENT_MAX = '1;   // event counter sticks at 65535

endpackage

//--- logic/histoCtrlPkg.sv
package histoCtrlPkg;

    import histoGeomPkg::*;

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        ACCUM,
        SCAN,
        SCANDRAIN
    } seqState_t;

    // register map
    localparam regAddr_t ADDR_CTRL   = 2'd0;  // wr: bit0 clear, bit1 search
    localparam regAddr_t ADDR_STATUS = 2'd1;  // bit0 busy, bit1 peakValid, bit2 accumulating
    localparam regAddr_t ADDR_PEAK   = 2'd2;  // count in high byte, bin in low byte
    localparam regAddr_t ADDR_EVENTS = 2'd3;

    typedef struct packed {
        logic clearReq;
        logic searchReq;
    } seqCmd_t;

    typedef struct packed {
        logic busy;
        logic accumulating;
        logic accepted;     // one pulse per counted event
    } seqStatus_t;

    typedef struct packed {
        logic      valid;
        logic      first;
        logic      last;
        binIdx_t   bin;
        binCount_t count;
    } scanBeat_t;

    typedef struct packed {
        logic      valid;
        binIdx_t   bin;
        binCount_t count;
    } peakResult_t;

endpackage

//--- logic/histoRegs.sv
module histoRegs import histoGeomPkg::*, histoCtrlPkg::*; (
    input  logic        clk,
    input  logic        res,
    input  logic        regWrite,
    input  regAddr_t    regAddr,
    input  regData_t    regWData,
    input  seqStatus_t  status,
    input  peakResult_t peak,
    output regData_t    regRData,
    output seqCmd_t     cmd
);

    logic     ctrlWrite;
    regData_t eventCount;
    logic     peakArmed;    // a search was issued since the last clear
    logic     peakValid;

    // commands only get through while the sequencer is free
    assign ctrlWrite = regWrite && (regAddr == ADDR_CTRL) && !status.busy;

    assign cmd = '{
        clearReq:  ctrlWrite && regWData[0],
        searchReq: ctrlWrite && regWData[1] && !regWData[0]  // clear wins
    };

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            eventCount <= '0;
        end else if (cmd.clearReq) begin
            eventCount <= '0;
        end else if (status.accepted && eventCount != EVENT_MAX) begin
            eventCount <= eventCount + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            peakArmed <= 1'b0;
        end else if (cmd.clearReq) begin
            peakArmed <= 1'b0;
        end else if (cmd.searchReq) begin
            peakArmed <= 1'b1;
        end
    end

    // peak finder holds the result, stale while a scan is running
    assign peakValid = peakArmed && peak.valid && !status.busy;

    always_comb begin
        case (regAddr)
            ADDR_STATUS: begin
                regRData = regData_t'({status.accumulating, peakValid, status.busy});
            end
            ADDR_PEAK: begin
                regRData = '0;
                if (peakValid) begin
                    regRData = {peak.count, {(8 - BIN_BITS){1'b0}}, peak.bin};
                end
            end
            ADDR_EVENTS: begin
                regRData = eventCount;
            end
            default: begin
                regRData = '0;    // CTRL is write only
            end
        endcase
    end

    cmdExclusive: assert property (@(posedge clk) disable iff (!res)
        !(cmd.clearReq && cmd.searchReq))
        else $error("clear and search requested in the same cycle");

    // the sequencer must pick up every clear on the next edge
    clearTaken: assert property (@(posedge clk) disable iff (!res)
        cmd.clearReq |=> status.busy)
        else $error("clear request not followed by busy");

endmodule

//--- logic/histoBinRam.sv
module histoBinRam import histoGeomPkg::*; (
    input  logic      clk,
    input  logic      wrEn,
    input  binIdx_t   wrAddr,
    input  binCount_t wrData,
    input  logic      rdEn,
    input  binIdx_t   rdAddr,
    output binCount_t rdData
);

    // contents are undefined until the sequencer runs a clear
    binCount_t mem [NUM_BINS];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // read before write on the same address returns the old count
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

//--- logic/histoPeakFinder.sv
module histoPeakFinder import histoGeomPkg::*, histoCtrlPkg::*; (
    input  logic        clk,
    input  logic        res,
    input  scanBeat_t   scan,
    output peakResult_t peak
);

    binIdx_t   maxBin;      // running maximum
    binCount_t maxCount;
    logic      takeBeat;
    binIdx_t   nextBin;
    binCount_t nextCount;

    // strictly greater, so a tie keeps the lower bin
    assign takeBeat  = scan.first || (scan.count > maxCount);
    assign nextBin   = takeBeat ? scan.bin : maxBin;
    assign nextCount = takeBeat ? scan.count : maxCount;

    always_ff @(posedge clk) begin
        if (scan.valid) begin
            maxBin   <= nextBin;
            maxCount <= nextCount;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            peak <= '0;
        end else if (scan.valid) begin
            if (scan.last) begin
                peak <= '{valid: 1'b1, bin: nextBin, count: nextCount};
            end else if (scan.first) begin
                peak.valid <= 1'b0;     // new scan, old result withdrawn
            end
        end
    end

    // beats come from the sequencer without gaps, one bin per cycle
    binStep: assert property (@(posedge clk) disable iff (!res)
        (scan.valid && !scan.last) |=>
            (scan.valid && scan.bin == binIdx_t'($past(scan.bin) + 1'b1)))
        else $error("scan beat out of order");

endmodule

//--- logic/histoSequencer.sv
module histoSequencer import histoGeomPkg::*, histoCtrlPkg::*; (
    input  logic       clk,
    input  logic       res,
    input  seqCmd_t    cmd,
    input  logic       eventValid,
    input  timeCode_t  eventTime,
    input  binCount_t  rdData,
    output seqStatus_t status,
    output logic       wrEn,
    output binIdx_t    wrAddr,
    output binCount_t  wrData,
    output logic       rdEn,
    output binIdx_t    rdAddr,
    output scanBeat_t  scan
);

    seqState_t state;
    seqState_t stateNext;
    binIdx_t   addrCnt;     // shared by clear and scan
    binIdx_t   eventBin;
    logic      accept;

    logic      s1Valid;     // accumulate write stage
    binIdx_t   s1Bin;
    logic      fwdValid;    // write done on the previous edge
    binIdx_t   fwdBin;
    binCount_t fwdData;
    binCount_t baseCount;
    binCount_t incCount;

    logic      beatValid;   // scan read in flight
    logic      beatFirst;
    logic      beatLast;
    binIdx_t   beatBin;

    always_comb begin
        stateNext = state;
        case (state)
            IDLE: begin
                if (cmd.clearReq) begin
                    stateNext = CLEAR;
                end
            end
            CLEAR: begin
                if (addrCnt == LAST_BIN) begin
                    stateNext = ACCUM;
                end
            end
            ACCUM: begin
                if (cmd.clearReq) begin
                    stateNext = CLEAR;
                end else if (cmd.searchReq) begin
                    stateNext = SCAN;
                end
            end
            SCAN: begin
                if (addrCnt == LAST_BIN) begin
                    stateNext = SCANDRAIN;
                end
            end
            SCANDRAIN: begin
                stateNext = ACCUM;  // last beat leaves this cycle
            end
            default: begin
                stateNext = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= IDLE;
            addrCnt   <= '0;
            s1Valid   <= 1'b0;
            fwdValid  <= 1'b0;
            beatValid <= 1'b0;
        end else begin
            state     <= stateNext;
            s1Valid   <= accept;
            fwdValid  <= s1Valid;
            beatValid <= (state == SCAN);
            if (state == CLEAR || state == SCAN) begin
                addrCnt <= addrCnt + 1'b1;  // wraps back to 0 on exit
            end
        end
    end

    always_ff @(posedge clk) begin
        s1Bin     <= eventBin;
        fwdBin    <= s1Bin;
        fwdData   <= incCount;
        beatFirst <= (addrCnt == '0);
        beatLast  <= (addrCnt == LAST_BIN);
        beatBin   <= addrCnt;
    end

    // events in a command cycle are dropped, the state is about to change
    assign eventBin = eventTime[TIME_BITS-1 -: BIN_BITS];
    assign accept   = eventValid && (state == ACCUM) && !cmd.clearReq && !cmd.searchReq;

    // RAM still holds the old count when the previous event hit the same bin
    assign baseCount = (fwdValid && fwdBin == s1Bin) ? fwdData : rdData;
    assign incCount  = (baseCount == COUNT_MAX) ? COUNT_MAX : baseCount + 1'b1;

    always_comb begin
        wrEn   = 1'b0;
        wrAddr = s1Bin;
        wrData = incCount;
        if (state == CLEAR) begin
            wrEn   = 1'b1;
            wrAddr = addrCnt;
            wrData = '0;
        end else if (s1Valid) begin
            wrEn = 1'b1;
        end
    end

    assign rdEn   = accept || (state == SCAN);
    assign rdAddr = (state == SCAN) ? addrCnt : eventBin;

    assign scan = '{
        valid: beatValid,
        first: beatFirst,
        last:  beatLast,
        bin:   beatBin,
        count: rdData
    };

    assign status = '{
        busy:         (state == CLEAR) || (state == SCAN) || (state == SCANDRAIN),
        accumulating: (state == ACCUM),
        accepted:     s1Valid
    };

    wrEnSource: assert property (@(posedge clk) disable iff (!res)
        wrEn |-> (state == CLEAR) || (s1Valid && state == ACCUM))
        else $error("bin write outside clear or accumulate");

    noWrap: assert property (@(posedge clk) disable iff (!res)
        (wrEn && state == ACCUM) |-> (wrData != '0))
        else $error("bin count wrapped to zero");

endmodule

//--- logic/histoTop.sv
module histoTop import histoGeomPkg::*, histoCtrlPkg::*; (
    input  logic      clk,
    input  logic      res,
    input  logic      eventValid,
    input  timeCode_t eventTime,
    input  logic      regWrite,
    input  regAddr_t  regAddr,
    input  regData_t  regWData,
    output regData_t  regRData
);

    seqCmd_t     cmd;
    seqStatus_t  status;
    scanBeat_t   scan;
    peakResult_t peak;

    logic        wrEn;      // bin memory ports
    binIdx_t     wrAddr;
    binCount_t   wrData;
    logic        rdEn;
    binIdx_t     rdAddr;
    binCount_t   rdData;

    histoRegs regs_i (
        .clk      (clk),
        .res      (res),
        .regWrite (regWrite),
        .regAddr  (regAddr),
        .regWData (regWData),
        .status   (status),
        .peak     (peak),
        .regRData (regRData),
        .cmd      (cmd)
    );

    histoSequencer seq_i (
        .clk        (clk),
        .res        (res),
        .cmd        (cmd),
        .eventValid (eventValid),
        .eventTime  (eventTime),
        .rdData     (rdData),
        .status     (status),
        .wrEn       (wrEn),
        .wrAddr     (wrAddr),
        .wrData     (wrData),
        .rdEn       (rdEn),
        .rdAddr     (rdAddr),
        .scan       (scan)
    );

    histoBinRam ram_i (
        .clk    (clk),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .rdEn   (rdEn),
        .rdAddr (rdAddr),
        .rdData (rdData)
    );

    histoPeakFinder peak_i (
        .clk  (clk),
        .res  (res),
        .scan (scan),
        .peak (peak)
    );

endmodule

//--- sim/histoTb.sv
module histoTb import histoGeomPkg::*, histoCtrlPkg::*; ();

    logic      clk;
    logic      res;
    logic      eventValid;
    timeCode_t eventTime;
    logic      regWrite;
    regAddr_t  regAddr;
    regData_t  regWData;
    regData_t  regRData;

    int        seed = 78669;
    int        modelCount [NUM_BINS];   // reference histogram
    int        modelEvents;
    int        checkErrors = 0;
    int        errorMark;
    int        testsPassed = 0;
    int        testsFailed = 0;
    regData_t  rd;

    histoTop dut_i (
        .clk        (clk),
        .res        (res),
        .eventValid (eventValid),
        .eventTime  (eventTime),
        .regWrite   (regWrite),
        .regAddr    (regAddr),
        .regWData   (regWData),
        .regRData   (regRData)
    );

    always #20 clk = ~clk;

    task automatic writeReg(input regAddr_t a, input regData_t d);
        @(negedge clk);
        regWrite = 1'b1;
        regAddr  = a;
        regWData = d;
        @(negedge clk);
        regWrite = 1'b0;
    endtask

    // regRData follows regAddr combinationally
    task automatic readReg(input regAddr_t a, output regData_t d);
        @(negedge clk);
        regAddr = a;
        #1;
        d = regRData;
    endtask

    task automatic waitIdle();
        regData_t st;
        int       polls;
        polls = 0;
        readReg(ADDR_STATUS, st);
        while (st[0] && polls < 500) begin
            polls++;
            readReg(ADDR_STATUS, st);
        end
        if (st[0]) begin
            $display("timeout: sequencer still busy after %0d status polls", polls);
            $display("Something failed");
            $finish;
        end
    endtask

    task automatic checkEqual(input regData_t got, input regData_t exp, input string what);
        assert (got === exp)
        else begin
            $display("FAILED at time %0t: %s read 0x%0h, expected 0x%0h", $time, what, got, exp);
            checkErrors++;
        end
    endtask

    task automatic resetModel();
        for (int b = 0; b < NUM_BINS; b++) begin
            modelCount[b] = 0;
        end
        modelEvents = 0;
    endtask

    // one event per falling edge, so calls in a row are back to back
    task automatic driveEvent(input timeCode_t t, input bit counted);
        int b;
        b = t >> (TIME_BITS - BIN_BITS);    // upper bits pick the bin
        @(negedge clk);
        eventValid = 1'b1;
        eventTime  = t;
        if (counted) begin
            if (modelCount[b] < 255) begin
                modelCount[b]++;
            end
            if (modelEvents < 65535) begin
                modelEvents++;
            end
        end
    endtask

    task automatic stopEvents();
        @(negedge clk);
        eventValid = 1'b0;
    endtask

    function automatic timeCode_t timeForBin(input int b);
        return timeCode_t'((b << (TIME_BITS - BIN_BITS)) | ($random(seed) & 15));
    endfunction

    // first maximum wins, so ties give the lowest bin
    function automatic regData_t expectedPeak();
        int best;
        best = 0;
        for (int b = 1; b < NUM_BINS; b++) begin
            if (modelCount[b] > modelCount[best]) begin
                best = b;
            end
        end
        return regData_t'((modelCount[best] << 8) | best);
    endfunction

    task automatic clearHistogram();
        writeReg(ADDR_CTRL, 16'h0001);
        waitIdle();
        resetModel();
    endtask

    task automatic runSearchAndCheck(input string what);
        regData_t d;
        writeReg(ADDR_CTRL, 16'h0002);
        waitIdle();
        readReg(ADDR_PEAK, d);
        checkEqual(d, expectedPeak(), what);
        readReg(ADDR_EVENTS, d);
        checkEqual(d, regData_t'(modelEvents), "EVENTS");
    endtask

    task automatic finishTest(input string name);
        if (checkErrors == errorMark) begin
            testsPassed++;
            $display("test %s: passed", name);
        end else begin
            testsFailed++;
            $display("test %s: failed", name);
        end
        errorMark = checkErrors;
    endtask

    initial begin
        clk        = 1'b0;
        res        = 1'b0;
        eventValid = 1'b0;
        eventTime  = '0;
        regWrite   = 1'b0;
        regAddr    = '0;
        regWData   = '0;
        errorMark  = 0;
        resetModel();
        repeat (2) @(posedge clk);
        @(negedge clk);
        res = 1'b1;

        // 1: nothing is counted before the first clear
        readReg(ADDR_STATUS, rd);
        checkEqual(rd, 16'h0000, "STATUS after reset");
        for (int i = 0; i < 10; i++) begin
            driveEvent(timeCode_t'($random(seed)), 1'b0);
        end
        stopEvents();
        readReg(ADDR_EVENTS, rd);
        checkEqual(rd, 16'h0000, "EVENTS before clear");
        finishTest("reset and idle drop");

        // 2
        clearHistogram();
        readReg(ADDR_STATUS, rd);
        checkEqual(rd, 16'h0004, "STATUS after clear");
        runSearchAndCheck("PEAK of empty histogram");
        readReg(ADDR_STATUS, rd);
        checkEqual(rd, 16'h0006, "STATUS after search");
        finishTest("clear");

        // 3
        for (int i = 0; i < 300; i++) begin
            driveEvent(timeCode_t'($random(seed)), 1'b1);
        end
        for (int i = 0; i < 40; i++) begin
            driveEvent(timeForBin(29), 1'b1);   // same bin every cycle
        end
        stopEvents();
        runSearchAndCheck("PEAK after random events");
        finishTest("random accumulation");

        // 4
        clearHistogram();
        for (int i = 0; i < 300; i++) begin
            driveEvent(timeForBin(17), 1'b1);
        end
        stopEvents();
        runSearchAndCheck("PEAK of saturated bin");
        readReg(ADDR_PEAK, rd);
        checkEqual(rd, 16'hFF11, "PEAK count stuck at 255");
        finishTest("saturation");

        // 5: clear and events during the scan must not land
        clearHistogram();
        for (int i = 0; i < 100; i++) begin
            driveEvent(timeCode_t'($random(seed)), 1'b1);
        end
        stopEvents();
        writeReg(ADDR_CTRL, 16'h0002);
        writeReg(ADDR_CTRL, 16'h0001);          // dropped while busy
        for (int i = 0; i < 30; i++) begin
            driveEvent(timeForBin(5), 1'b0);
        end
        stopEvents();
        waitIdle();
        readReg(ADDR_PEAK, rd);
        checkEqual(rd, expectedPeak(), "PEAK with clear during search");
        readReg(ADDR_EVENTS, rd);
        checkEqual(rd, regData_t'(modelEvents), "EVENTS with events during search");
        runSearchAndCheck("PEAK of second search");
        finishTest("commands while busy");

        // 6: bins 3 and 10 tie at three, lower bin expected
        clearHistogram();
        readReg(ADDR_EVENTS, rd);
        checkEqual(rd, 16'h0000, "EVENTS after re-clear");
        readReg(ADDR_STATUS, rd);
        checkEqual(rd, 16'h0004, "STATUS after re-clear");
        for (int i = 0; i < 3; i++) begin
            driveEvent(timeForBin(10), 1'b1);
            driveEvent(timeForBin(3), 1'b1);
        end
        driveEvent(timeForBin(40), 1'b1);
        driveEvent(timeForBin(40), 1'b1);
        stopEvents();
        runSearchAndCheck("PEAK after directed events");
        readReg(ADDR_PEAK, rd);
        checkEqual(rd, 16'h0303, "PEAK tie keeps lower bin");
        finishTest("re-clear");

        $display("tests passed %0d, tests failed %0d", testsPassed, testsFailed);
        if (checkErrors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- files.f
logic/histoGeomPkg.sv
logic/histoCtrlPkg.sv
logic/histoRegs.sv
logic/histoBinRam.sv
logic/histoPeakFinder.sv
logic/histoSequencer.sv
logic/histoTop.sv
sim/histoTb.sv
